/* logic/cpu_consts.svh */
/*
 cpu constants: widths, opcode and funct codes, reset pc
 */
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

`define WORD_W    32
`define REG_W     5
`define NUM_REGS  32
`define PC_INIT   32'h0000_0000
`define RAM_WORDS 256

// opcodes, instr[31:26]
`define OP_RTYPE  6'h00
`define OP_J      6'h02
`define OP_BEQ    6'h04
`define OP_BNE    6'h05
`define OP_ADDIU  6'h09
`define OP_ORI    6'h0d
`define OP_LW     6'h23
`define OP_SW     6'h2b
`define OP_HALT   6'h3f

// funct field for r-type, instr[5:0]
`define FN_ADDU   6'h21
`define FN_SUBU   6'h23
`define FN_AND    6'h24
`define FN_OR     6'h25
`define FN_SLT    6'h2a

`endif

/* logic/cpu_types_pkg.sv */
/*
 cpu types: data words, control encodings, stage latch payloads
 and the single ram port request
 */
`include "cpu_consts.svh"

package cpu_types_pkg;

   typedef logic [`WORD_W-1:0] word_t;
   typedef logic [`REG_W-1:0]  regbits_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_SLT
   } alu_op_t;

   typedef enum logic {DST_RD, DST_RT} regdst_t;
   typedef enum logic [1:0] {SRC_REG, SRC_SIMM, SRC_ZIMM} alu_src_t;
   typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_t;
   typedef enum logic [1:0] {FWD_REG, FWD_MEM, FWD_WB} fwd_sel_t;

   // all zero is a bubble
   typedef struct packed {
      logic     regwr;
      regdst_t  regdst;
      alu_src_t alu_src;
      alu_op_t  alu_op;
      logic     dren;
      logic     dwen;
      logic     memtoreg;
      branch_t  branch;
      logic     jump;
      logic     halt;
   } ctrl_t;

   // control bits still needed after execute
   typedef struct packed {
      logic regwr;
      logic dren;
      logic dwen;
      logic memtoreg;
      logic halt;
   } em_ctrl_t;

   ////////////////////////////////////////
   // stage latch payloads
   ////////////////////////////////////////
   typedef struct packed {
      word_t instr;
      word_t pc_plus_4;
   } fd_t;

   typedef struct packed {
      ctrl_t       ctrl;
      word_t       rdat1;
      word_t       rdat2;
      word_t       imm;       // already extended
      logic [25:0] imm26;
      regbits_t    rs;
      regbits_t    rt;
      regbits_t    rd;
      word_t       pc_plus_4;
   } de_t;

   typedef struct packed {
      em_ctrl_t ctrl;
      word_t    alu_res;
      word_t    store;        // forwarded rt for sw
      regbits_t wsel;
   } em_t;

   typedef struct packed {
      logic     regwr;
      logic     memtoreg;
      word_t    alu_res;
      word_t    dmemload;
      regbits_t wsel;
      logic     halt;
   } mw_t;

   typedef struct packed {
      word_t addr;
      word_t wdata;
      logic  ren;
      logic  wen;
   } ram_req_t;

endpackage

/* logic/control_unit.sv */
/*
 control unit, turns one instruction word into the control struct
 */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module control_unit (
   input  cpu_types_pkg::word_t instr,
   output cpu_types_pkg::ctrl_t ctrl,
   output logic                 extop
);

   logic [5:0] opcode;
   logic [5:0] funct;

   assign opcode = instr[31:26];
   assign funct  = instr[5:0];

   always_comb begin
      ctrl = '0;   // bubble unless decoded below
      unique case (opcode)
         `OP_RTYPE: begin
            ctrl.regwr  = 1'b1;
            ctrl.regdst = cpu_types_pkg::DST_RD;
            case (funct)
               `FN_ADDU: ctrl.alu_op = cpu_types_pkg::ALU_ADD;
               `FN_SUBU: ctrl.alu_op = cpu_types_pkg::ALU_SUB;
               `FN_AND:  ctrl.alu_op = cpu_types_pkg::ALU_AND;
               `FN_OR:   ctrl.alu_op = cpu_types_pkg::ALU_OR;
               `FN_SLT:  ctrl.alu_op = cpu_types_pkg::ALU_SLT;
               default:  ctrl = '0;   // unsupported funct
            endcase
         end
         `OP_ADDIU: begin
            ctrl.regwr   = 1'b1;
            ctrl.regdst  = cpu_types_pkg::DST_RT;
            ctrl.alu_src = cpu_types_pkg::SRC_SIMM;
         end
         `OP_ORI: begin
            ctrl.regwr   = 1'b1;
            ctrl.regdst  = cpu_types_pkg::DST_RT;
            ctrl.alu_src = cpu_types_pkg::SRC_ZIMM;
            ctrl.alu_op  = cpu_types_pkg::ALU_OR;
         end
         `OP_LW: begin
            ctrl.regwr    = 1'b1;
            ctrl.regdst   = cpu_types_pkg::DST_RT;
            ctrl.alu_src  = cpu_types_pkg::SRC_SIMM;
            ctrl.dren     = 1'b1;
            ctrl.memtoreg = 1'b1;
         end
         `OP_SW: begin
            ctrl.alu_src = cpu_types_pkg::SRC_SIMM;   // address = rs + offset
            ctrl.dwen    = 1'b1;
         end
         `OP_BEQ:  ctrl.branch = cpu_types_pkg::BR_EQ;
         `OP_BNE:  ctrl.branch = cpu_types_pkg::BR_NE;
         `OP_J:    ctrl.jump   = 1'b1;
         `OP_HALT: ctrl.halt   = 1'b1;
         default:  ctrl = '0;
      endcase
   end

   // only ori zero extends, branches need the signed offset
   assign extop = (opcode != `OP_ORI);

endmodule

/* logic/register_file.sv */
/*
 register file, 32 x 32, r0 hardwired to zero
 written on the falling edge so decode sees writeback data
 */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module register_file (
   input  logic                    CLK,
   input  logic                    nRST,
   input  cpu_types_pkg::regbits_t rsel1,
   input  cpu_types_pkg::regbits_t rsel2,
   input  cpu_types_pkg::regbits_t wsel,
   input  logic                    wen,
   input  cpu_types_pkg::word_t    wdat,
   output cpu_types_pkg::word_t    rdat1,
   output cpu_types_pkg::word_t    rdat2
);

   cpu_types_pkg::word_t regs [`NUM_REGS];

   always_ff @(negedge CLK, negedge nRST) begin
      if (!nRST) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wen && (wsel != '0)) begin
         regs[wsel] <= wdat;
      end
   end

   assign rdat1 = regs[rsel1];
   assign rdat2 = regs[rsel2];

   a_r0_zero: assert property (@(posedge CLK) disable iff (!nRST)
      (rsel1 == '0) |-> (rdat1 == '0));

endmodule

/* logic/hazard_unit.sv */
/*
 hazard unit, forwarding selects plus stage enables and flushes
 */
`timescale 1ns/1ps

module hazard_unit (
   input  cpu_types_pkg::regbits_t de_rs,
   input  cpu_types_pkg::regbits_t de_rt,
   input  cpu_types_pkg::regbits_t em_wsel,
   input  cpu_types_pkg::regbits_t mw_wsel,
   input  logic                    em_regwr,
   input  logic                    mw_regwr,
   input  logic                    em_dren,
   input  logic                    em_dwen,
   input  logic                    ihit,
   input  logic                    dhit,
   input  logic                    redirect,
   input  logic                    halted,
   output cpu_types_pkg::fwd_sel_t fwd_a,
   output cpu_types_pkg::fwd_sel_t fwd_b,
   output logic                    pc_en,
   output logic                    fd_en,
   output logic                    fd_flush,
   output logic                    de_en,
   output logic                    de_flush,
   output logic                    em_en,
   output logic                    em_flush,
   output logic                    mw_en
);

   logic mem_wait;
   logic load_use;

   function automatic cpu_types_pkg::fwd_sel_t pick(cpu_types_pkg::regbits_t src);
      if (em_regwr && (em_wsel != '0) && (em_wsel == src))
         return cpu_types_pkg::FWD_MEM;   // youngest producer wins
      else if (mw_regwr && (mw_wsel != '0) && (mw_wsel == src))
         return cpu_types_pkg::FWD_WB;
      else
         return cpu_types_pkg::FWD_REG;
   endfunction

   always_comb begin
      fwd_a = pick(de_rs);
      fwd_b = pick(de_rt);
   end

   assign mem_wait = (em_dren || em_dwen) && !dhit;
   // load in mem, consumer in ex: alu_res is only the address there
   assign load_use = em_dren && (em_wsel != '0) &&
                     ((em_wsel == de_rs) || (em_wsel == de_rt));

   always_comb begin
      pc_en    = 1'b1;
      fd_en    = 1'b1;
      de_en    = 1'b1;
      em_en    = 1'b1;
      mw_en    = 1'b1;
      fd_flush = 1'b0;
      de_flush = 1'b0;
      em_flush = 1'b0;
      if (mem_wait) begin   // freeze everything
         pc_en = 1'b0;
         fd_en = 1'b0;
         de_en = 1'b0;
         em_en = 1'b0;
         mw_en = 1'b0;
      end else if (load_use) begin
         // redirect ignored here, branch operands not valid yet
         pc_en    = 1'b0;
         fd_en    = 1'b0;
         de_en    = 1'b0;
         em_flush = 1'b1;   // one bubble behind the load
      end else if (redirect) begin
         fd_flush = 1'b1;
         de_flush = 1'b1;
      end else if (halted || !ihit) begin
         pc_en    = 1'b0;
         fd_flush = 1'b1;
      end
   end

   // a flush is only applied on an enabled latch
   always_comb begin
      a_no_flush_hold: assert ((!fd_flush || fd_en) && (!de_flush || de_en) &&
                               (!em_flush || em_en));
   end

endmodule

/* logic/pipeline_reg.sv */
/*
 generic stage latch, hold on !en, bubble on flush
 */
`timescale 1ns/1ps

module pipeline_reg #(
   parameter type payload_t = logic
) (
   input  logic     CLK,
   input  logic     nRST,
   input  logic     en,
   input  logic     flush,
   input  payload_t d,
   output payload_t q
);

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) begin
         q <= '0;
      end else if (en) begin
         q <= flush ? payload_t'('0) : d;   // zero payload is a bubble
      end
   end

endmodule

/* logic/datapath.sv */
/*
 five stage datapath: pc, stage latches, forwarding, alu,
 branch resolution in execute and the sticky halt
 */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module datapath (
   input  logic                    CLK,
   input  logic                    nRST,
   input  cpu_types_pkg::word_t    imem_load,
   input  logic                    ihit,
   input  cpu_types_pkg::word_t    dmem_load,
   input  logic                    dhit,
   output cpu_types_pkg::word_t    imem_addr,
   output cpu_types_pkg::ram_req_t dmem_req,
   output logic                    halt
);

   cpu_types_pkg::fd_t fd_d, fd_q;
   cpu_types_pkg::de_t de_d, de_q;
   cpu_types_pkg::em_t em_d, em_q;
   cpu_types_pkg::mw_t mw_d, mw_q;

   cpu_types_pkg::word_t    pc, next_pc;
   cpu_types_pkg::ctrl_t    dec_ctrl;
   logic                    extop;
   cpu_types_pkg::word_t    rdat1, rdat2;
   cpu_types_pkg::fwd_sel_t fwd_a, fwd_b;
   logic pc_en, fd_en, fd_flush, de_en, de_flush, em_en, em_flush, mw_en;
   cpu_types_pkg::word_t    op_a, op_b_reg, op_b, alu_res, wb_data;
   cpu_types_pkg::word_t    br_target, j_target;
   logic                    taken, redirect, fetch_stop;

   ////////////////////////////////////////
   // fetch
   ////////////////////////////////////////
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) pc <= `PC_INIT;
      else if (pc_en) pc <= next_pc;
   end

   assign next_pc = !redirect ? pc + 32'd4 :
                    de_q.ctrl.jump ? j_target : br_target;
   assign imem_addr = pc;

   assign fd_d.instr     = imem_load;
   assign fd_d.pc_plus_4 = pc + 32'd4;

   pipeline_reg #(.payload_t(cpu_types_pkg::fd_t)) if_id (
      .CLK, .nRST, .en(fd_en), .flush(fd_flush), .d(fd_d), .q(fd_q));

   ////////////////////////////////////////
   // decode
   ////////////////////////////////////////
   control_unit cu (.instr(fd_q.instr), .ctrl(dec_ctrl), .extop);

   register_file rf (
      .CLK, .nRST,
      .rsel1(fd_q.instr[25:21]), .rsel2(fd_q.instr[20:16]),
      .wsel(mw_q.wsel), .wen(mw_q.regwr), .wdat(wb_data),
      .rdat1, .rdat2);

   assign de_d.ctrl      = dec_ctrl;
   assign de_d.rdat1     = rdat1;
   assign de_d.rdat2     = rdat2;
   assign de_d.imm       = extop ? {{16{fd_q.instr[15]}}, fd_q.instr[15:0]}
                                 : {16'h0000, fd_q.instr[15:0]};
   assign de_d.imm26     = fd_q.instr[25:0];
   assign de_d.rs        = fd_q.instr[25:21];
   assign de_d.rt        = fd_q.instr[20:16];
   assign de_d.rd        = fd_q.instr[15:11];
   assign de_d.pc_plus_4 = fd_q.pc_plus_4;

   // a halt that made it into id/ex is past every older branch
   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) fetch_stop <= 1'b0;
      else if (dec_ctrl.halt && de_en && !de_flush) fetch_stop <= 1'b1;
   end

   hazard_unit hz (
      .de_rs(de_q.rs), .de_rt(de_q.rt), .em_wsel(em_q.wsel), .mw_wsel(mw_q.wsel),
      .em_regwr(em_q.ctrl.regwr), .mw_regwr(mw_q.regwr),
      .em_dren(em_q.ctrl.dren), .em_dwen(em_q.ctrl.dwen),
      .ihit, .dhit, .redirect, .halted(dec_ctrl.halt || fetch_stop),
      .fwd_a, .fwd_b, .pc_en, .fd_en, .fd_flush, .de_en, .de_flush,
      .em_en, .em_flush, .mw_en);

   pipeline_reg #(.payload_t(cpu_types_pkg::de_t)) id_ex (
      .CLK, .nRST, .en(de_en), .flush(de_flush), .d(de_d), .q(de_q));

   ////////////////////////////////////////
   // execute
   ////////////////////////////////////////
   always_comb begin
      case (fwd_a)
         cpu_types_pkg::FWD_MEM: op_a = em_q.alu_res;
         cpu_types_pkg::FWD_WB:  op_a = wb_data;
         default:                op_a = de_q.rdat1;
      endcase
      case (fwd_b)
         cpu_types_pkg::FWD_MEM: op_b_reg = em_q.alu_res;
         cpu_types_pkg::FWD_WB:  op_b_reg = wb_data;
         default:                op_b_reg = de_q.rdat2;
      endcase
   end

   assign op_b = (de_q.ctrl.alu_src == cpu_types_pkg::SRC_REG) ? op_b_reg : de_q.imm;

   always_comb begin
      case (de_q.ctrl.alu_op)
         cpu_types_pkg::ALU_SUB: alu_res = op_a - op_b;
         cpu_types_pkg::ALU_AND: alu_res = op_a & op_b;
         cpu_types_pkg::ALU_OR:  alu_res = op_a | op_b;
         cpu_types_pkg::ALU_SLT: alu_res = {31'd0, $signed(op_a) < $signed(op_b)};
         default:                alu_res = op_a + op_b;
      endcase
   end

   // branch compare on forwarded registers, predicted not taken
   assign taken = ((de_q.ctrl.branch == cpu_types_pkg::BR_EQ) && (op_a == op_b_reg)) ||
                  ((de_q.ctrl.branch == cpu_types_pkg::BR_NE) && (op_a != op_b_reg));
   assign redirect  = taken || de_q.ctrl.jump;
   assign br_target = de_q.pc_plus_4 + {de_q.imm[29:0], 2'b00};
   assign j_target  = {de_q.pc_plus_4[31:28], de_q.imm26, 2'b00};

   assign em_d.ctrl.regwr    = de_q.ctrl.regwr;
   assign em_d.ctrl.dren     = de_q.ctrl.dren;
   assign em_d.ctrl.dwen     = de_q.ctrl.dwen;
   assign em_d.ctrl.memtoreg = de_q.ctrl.memtoreg;
   assign em_d.ctrl.halt     = de_q.ctrl.halt;
   assign em_d.alu_res       = alu_res;
   assign em_d.store         = op_b_reg;
   assign em_d.wsel = (de_q.ctrl.regdst == cpu_types_pkg::DST_RT) ? de_q.rt : de_q.rd;

   pipeline_reg #(.payload_t(cpu_types_pkg::em_t)) ex_mem (
      .CLK, .nRST, .en(em_en), .flush(em_flush), .d(em_d), .q(em_q));

   ////////////////////////////////////////
   // memory and writeback
   ////////////////////////////////////////
   assign dmem_req.addr  = em_q.alu_res;
   assign dmem_req.wdata = em_q.store;
   assign dmem_req.ren   = em_q.ctrl.dren;
   assign dmem_req.wen   = em_q.ctrl.dwen;

   assign mw_d.regwr    = em_q.ctrl.regwr;
   assign mw_d.memtoreg = em_q.ctrl.memtoreg;
   assign mw_d.alu_res  = em_q.alu_res;
   assign mw_d.dmemload = dmem_load;
   assign mw_d.wsel     = em_q.wsel;
   assign mw_d.halt     = em_q.ctrl.halt;

   pipeline_reg #(.payload_t(cpu_types_pkg::mw_t)) mem_wb (
      .CLK, .nRST, .en(mw_en), .flush(1'b0), .d(mw_d), .q(mw_q));

   assign wb_data = mw_q.memtoreg ? mw_q.dmemload : mw_q.alu_res;

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) halt <= 1'b0;
      else if (mw_q.halt) halt <= 1'b1;   // sticky until reset
   end

   a_one_dmem_op: assert property (@(posedge CLK) disable iff (!nRST)
      !(dmem_req.ren && dmem_req.wen));

endmodule

/* logic/memory_control.sv */
/*
 memory controller, shares the single ram port between fetch and
 data access, data side first
 */
`timescale 1ns/1ps

module memory_control (
   input  logic                    CLK,
   input  logic                    nRST,
   input  cpu_types_pkg::word_t    imem_addr,
   input  cpu_types_pkg::ram_req_t dmem_req,
   input  cpu_types_pkg::word_t    ram_rdata,
   input  logic                    ram_ready,
   output cpu_types_pkg::ram_req_t ram_req,
   output cpu_types_pkg::word_t    imem_load,
   output cpu_types_pkg::word_t    dmem_load,
   output logic                    ihit,
   output logic                    dhit
);

   logic quiet;   // first cycle out of reset

   always_ff @(posedge CLK, negedge nRST) begin
      if (!nRST) quiet <= 1'b1;
      else       quiet <= 1'b0;
   end

   always_comb begin
      ram_req = '0;
      ihit    = 1'b0;
      dhit    = 1'b0;
      if (!quiet) begin
         if (dmem_req.ren || dmem_req.wen) begin
            ram_req = dmem_req;
            dhit    = ram_ready;
         end else begin
            ram_req.addr = imem_addr;
            ram_req.ren  = 1'b1;
            ihit         = ram_ready;
         end
      end
   end

   assign imem_load = ram_rdata;
   assign dmem_load = ram_rdata;

   // pipeline must keep an unanswered data request steady
   a_dreq_held: assert property (@(posedge CLK) disable iff (!nRST)
      (ram_req.wen && !ram_ready) |=> (ram_req.wen && $stable(ram_req.addr)));

endmodule

/* logic/pipe_cpu.sv */
/*
 pipelined cpu top, datapath and the shared memory port
 */
`timescale 1ns/1ps

module pipe_cpu (
   input  logic                    CLK,
   input  logic                    nRST,
   output cpu_types_pkg::ram_req_t ram_req,
   input  cpu_types_pkg::word_t    ram_rdata,
   input  logic                    ram_ready,
   output logic                    halt
);

   cpu_types_pkg::word_t    imem_addr;
   cpu_types_pkg::word_t    imem_load;
   cpu_types_pkg::word_t    dmem_load;
   cpu_types_pkg::ram_req_t dmem_req;
   logic                    ihit;
   logic                    dhit;

   datapath dp (
      .CLK, .nRST, .imem_load, .ihit, .dmem_load, .dhit,
      .imem_addr, .dmem_req, .halt);

   memory_control mc (
      .CLK, .nRST, .imem_addr, .dmem_req, .ram_rdata, .ram_ready,
      .ram_req, .imem_load, .dmem_load, .ihit, .dhit);

endmodule

/* sim/tb_ram.sv */
/*
 single port ram model for the cpu, random wait states,
 combinational read data, write on the clock when ready
 */
`timescale 1ns/1ps
`include "cpu_consts.svh"

module tb_ram (
   input  logic                    CLK,
   input  cpu_types_pkg::ram_req_t req,
   output cpu_types_pkg::word_t    rdata,
   output logic                    ready
);

   localparam int IDX_W = $clog2(`RAM_WORDS);

   cpu_types_pkg::word_t mem [`RAM_WORDS];
   logic [31:0]          lfsr_state;

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   initial begin
      ready      = 1'b0;
      lfsr_state = 32'hca35_c39a;
      for (int i = 0; i < `RAM_WORDS; i++) begin
         mem[i] = '0;
      end
      $readmemh("sim/program.hex", mem);
   end

   // about 60% of cycles ready
   always @(posedge CLK) begin
      #1;
      lfsr_state = xorshift32(lfsr_state);
      ready <= (lfsr_state[7:0] < 8'd154);
   end

   assign rdata = mem[req.addr[IDX_W+1:2]];   // word addressed

   always @(posedge CLK) begin
      if (req.wen && ready) mem[req.addr[IDX_W+1:2]] <= req.wdata;
   end

endmodule

/* sim/tb_pipe_cpu.sv */
/*
 testbench for the pipelined cpu, runs the program and checks
 every store against the result table
 */
`timescale 1ns/1ps

module tb_pipe_cpu;

   localparam int NUM_TESTS      = 11;
   localparam int PROG_INSTRS    = 50;
   localparam int CYCLES_PER_INS = 80;   // waits, stalls and flushes, worst case
   localparam int TIMEOUT_CYCLES = PROG_INSTRS * CYCLES_PER_INS;

   logic                    CLK;
   logic                    nRST;
   cpu_types_pkg::ram_req_t ram_req;
   cpu_types_pkg::word_t    ram_rdata;
   logic                    ram_ready;
   logic                    halt;

   cpu_types_pkg::word_t res_addr [NUM_TESTS];
   cpu_types_pkg::word_t res_val  [NUM_TESTS];
   string                res_name [NUM_TESTS];
   int                   write_cnt[NUM_TESTS];
   logic                 bad      [NUM_TESTS];
   int                   errors;

   pipe_cpu pipe_cpu_i (.CLK, .nRST, .ram_req, .ram_rdata, .ram_ready, .halt);
   tb_ram ram (.CLK, .req(ram_req), .rdata(ram_rdata), .ready(ram_ready));

   initial begin
      CLK = 1'b0;
      forever #5 CLK = ~CLK;
   end

   //////////////////////////////////////////
   // result table
   //////////////////////////////////////////
   task automatic add_entry(input int i, input cpu_types_pkg::word_t a,
                            input cpu_types_pkg::word_t v, input string n);
      res_addr[i]  = a;
      res_val[i]   = v;
      res_name[i]  = n;
      write_cnt[i] = 0;
      bad[i]       = 1'b0;
   endtask

   function automatic int entry_of(input cpu_types_pkg::word_t a);
      for (int i = 0; i < NUM_TESTS; i++) begin
         if (res_addr[i] == a) return i;
      end
      return -1;
   endfunction

   task automatic report_mismatch(input cpu_types_pkg::word_t a,
                                  input cpu_types_pkg::word_t v);
      int k;
      k = entry_of(a);
      $display("mismatch %s: expected 0x%08h, actual 0x%08h", res_name[k], res_val[k], v);
      bad[k] = 1'b1;
      errors++;
   endtask

   task automatic report_error(input string what);
      $display("error at %0t: %s", $time, what);
      errors++;
   endtask

   //////////////////////////////////////////
   // store checks
   //////////////////////////////////////////
   a_known_addr: assert property (@(posedge CLK) disable iff (!nRST)
      (ram_req.wen && ram_ready) |-> (entry_of(ram_req.addr) >= 0))
      else report_error($sformatf("store to address 0x%08h, which no test expects",
                                  $sampled(ram_req.addr)));

   a_store_value: assert property (@(posedge CLK) disable iff (!nRST)
      (ram_req.wen && ram_ready && (entry_of(ram_req.addr) >= 0))
      |-> (ram_req.wdata == res_val[entry_of(ram_req.addr)]))
      else report_mismatch($sampled(ram_req.addr), $sampled(ram_req.wdata));

   a_single_store: assert property (@(posedge CLK) disable iff (!nRST)
      (ram_req.wen && ram_ready && (entry_of(ram_req.addr) >= 0))
      |-> (write_cnt[entry_of(ram_req.addr)] == 0))
      else report_error($sformatf("second store to address 0x%08h",
                                  $sampled(ram_req.addr)));

   // ram port idle and halt low in the first cycle out of reset
   a_reset_quiet: assert property (@(posedge CLK)
      $rose(nRST) |-> (!ram_req.ren && !ram_req.wen && !halt))
      else report_error("ram port busy or halt high right after reset");

   a_halt_sticky: assert property (@(posedge CLK) disable iff (!nRST) halt |=> halt)
      else report_error("halt dropped before reset");

   a_no_write_after_halt: assert property (@(posedge CLK) disable iff (!nRST)
      halt |-> !ram_req.wen)
      else report_error("ram write requested after halt");

   always @(posedge CLK) begin
      int k;
      if (nRST && ram_req.wen && ram_ready) begin
         k = entry_of(ram_req.addr);
         if (k >= 0) write_cnt[k] <= write_cnt[k] + 1;
      end
   end

   // watchdog
   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge CLK);
      $display("timeout: halt did not rise within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
   end

   initial begin
      int passed;
      int failed;
      errors = 0;
      passed = 0;
      failed = 0;
      nRST   = 1'b0;
      add_entry(0,  32'h200, 32'd12,    "addu_fwd");
      add_entry(1,  32'h204, 32'd9,     "subu");
      add_entry(2,  32'h208, 32'd8,     "and");
      add_entry(3,  32'h20c, 32'd15,    "or");
      add_entry(4,  32'h210, 32'd1,     "slt");
      add_entry(5,  32'h214, 32'h0f0f,  "ori");
      add_entry(6,  32'h218, 32'h1234,  "sw_scratch");
      add_entry(7,  32'h21c, 32'h2468,  "load_use");
      add_entry(8,  32'h220, 32'd15,    "bne_loop");
      add_entry(9,  32'h224, 32'd1,     "beq_fall");
      add_entry(10, 32'h228, 32'h0055,  "jump_skip");
      repeat (5) @(posedge CLK);
      #1 nRST = 1'b1;
      wait (halt);
      repeat (10) @(posedge CLK);   // let the halt checks run a while
      for (int i = 0; i < NUM_TESTS; i++) begin
         if (!bad[i] && write_cnt[i] == 1) begin
            $display("%-12s ok", res_name[i]);
            passed++;
         end else begin
            $display("%-12s failed, stored %0d times", res_name[i], write_cnt[i]);
            failed++;
         end
      end
      $display("summary: %0d passed, %0d failed, %0d errors", passed, failed, errors);
      if (errors == 0 && failed == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* pipe_cpu.f */
+incdir+logic
logic/cpu_types_pkg.sv
logic/control_unit.sv
logic/register_file.sv
logic/hazard_unit.sv
logic/pipeline_reg.sv
logic/datapath.sv
logic/memory_control.sv
logic/pipe_cpu.sv
sim/tb_ram.sv
sim/tb_pipe_cpu.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_pipe_cpu
FILELIST  = pipe_cpu.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* sim/program.hex */
// columns: four 32-bit instruction words per line, from byte address 0 up
// results go to 0x200 + offset, base held in r20
34140200 24010007 24020005 00221821  // ori r20, addiu r1=7, r2=5, addu r3=12
24040003 00642823 00A33024 00C13825  // addiu r4=3, subu r5=9, and r6=8, or r7=15
0087402A 34E90F00 AE830000 AE850004  // slt r8=1, ori r9=0xf0f, sw r3, sw r5
AE860008 AE87000C AE880010 AE890014  // sw r6, sw r7, sw r8, sw r9
240A1234 AE8A0018 8E8B0018 016B6021  // r10=0x1234, sw, lw r11, addu r12 uses r11
AE8C001C 240D0000 240E0000 240F0005  // sw r12, sum=0, i=0, limit=5
25CE0001 01AE6821 15CFFFFD AE8D0020  // loop: i++, sum+=i, bne back, sw sum
10220001 24100001 AE900024 08000022  // beq r1,r2 not taken, r16=1, sw r16, j 0x88
AE810040 AE810040 24110055 AE910028  // two poison stores skipped, r17=0x55, sw
FC000000                             // halt
